//--- frame_pkg.sv
package frame_pkg;

    localparam int frame_bytes = 12;
    localparam int body_bytes  = 10; // identifier and payload, the part the checksum covers

    typedef logic [8*body_bytes-1:0] body_t;
    typedef logic [15:0] csum_t;

    typedef struct packed {
        logic [31:0] id;
        logic [47:0] payload;
        csum_t       csum;
    } frame_fields_t;

    // b[frame_bytes-1] holds the first byte on the line
    typedef union packed {
        frame_fields_t                f;
        logic [frame_bytes-1:0][7:0] b;
    } frame_u;

endpackage

//--- uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
    parameter int clk_freq = 1000000,
    parameter int baud     = 125000
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       rxd,
    output logic [7:0] rx_byte,
    output logic       rx_byte_valid,
    output logic       rx_eop
);

    localparam int bit_clks = clk_freq / baud;
    localparam int gap_clks = 16 * bit_clks;
    localparam int bw       = $clog2(bit_clks);
    localparam int gw       = $clog2(gap_clks + 1);

    localparam logic [bw-1:0] bit_last  = bw'(bit_clks - 1);
    localparam logic [bw-1:0] half_last = bw'(bit_clks / 2 - 1);
    localparam logic [gw-1:0] gap_last  = gw'(gap_clks - 1);
    localparam logic [gw-1:0] gap_full  = gw'(gap_clks);

    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_start = 2'd1;
    localparam logic [1:0] st_data  = 2'd2;
    localparam logic [1:0] st_stop  = 2'd3;

    logic [1:0]    sync_q;
    logic [1:0]    state;
    logic [bw-1:0] clk_cnt;
    logic [2:0]    bit_idx;
    logic [7:0]    shift;
    logic [gw-1:0] idle_cnt;
    logic          got_byte; // a byte has arrived since the last gap
    logic          rxd_s;

    assign rxd_s   = sync_q[1];
    assign rx_byte = shift;

    always_ff @(posedge clk) begin
        if (rst) begin
            sync_q        <= 2'b11;
            state         <= st_idle;
            clk_cnt       <= '0;
            bit_idx       <= '0;
            idle_cnt      <= '0;
            got_byte      <= 1'b0;
            rx_byte_valid <= 1'b0;
            rx_eop        <= 1'b0;
        end else begin
            sync_q        <= {sync_q[0], rxd};
            rx_byte_valid <= 1'b0;
            rx_eop        <= 1'b0;
            clk_cnt       <= clk_cnt + 1'b1;
            case (state)
                st_idle: begin
                    clk_cnt <= '0;
                    if (!rxd_s) state <= st_start;
                end
                st_start: begin
                    if (clk_cnt == half_last) begin // middle of the start bit
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rxd_s ? st_idle : st_data;
                    end
                end
                st_data: begin
                    if (clk_cnt == bit_last) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= st_stop;
                    end
                end
                default: begin
                    if (clk_cnt == bit_last) begin
                        state <= st_idle;
                        if (rxd_s) begin // a low stop bit drops the byte
                            rx_byte_valid <= 1'b1;
                            got_byte      <= 1'b1;
                        end
                    end
                end
            endcase

            if (state != st_idle || !rxd_s) begin
                idle_cnt <= '0;
            end else if (idle_cnt != gap_full) begin
                idle_cnt <= idle_cnt + 1'b1;
            end
            if (state == st_idle && rxd_s && idle_cnt == gap_last && got_byte) begin
                rx_eop   <= 1'b1;
                got_byte <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_data && clk_cnt == bit_last) begin
            shift <= {rxd_s, shift[7:1]}; // lsb arrives first
        end
    end

endmodule

//--- uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
    parameter int clk_freq = 1000000,
    parameter int baud     = 125000
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       txb_valid,
    input  logic [7:0] txb_data,
    output logic       txb_ready,
    output logic       tx_idle,
    output logic       txd
);

    localparam int bit_clks = clk_freq / baud;
    localparam int bw       = $clog2(bit_clks);

    localparam logic [bw-1:0] bit_last = bw'(bit_clks - 1);

    logic          busy;
    logic [8:0]    shift; // data bits then the stop bit
    logic [3:0]    bit_cnt;
    logic [bw-1:0] clk_cnt;

    assign txb_ready = !busy;
    assign tx_idle   = !busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            clk_cnt <= '0;
            txd     <= 1'b1;
        end else if (!busy) begin
            if (txb_valid) begin
                busy    <= 1'b1;
                bit_cnt <= '0;
                clk_cnt <= '0;
                txd     <= 1'b0; // start bit
            end
        end else if (clk_cnt == bit_last) begin
            clk_cnt <= '0;
            if (bit_cnt == 4'd9) begin
                busy <= 1'b0; // stop bit has run its full period
                txd  <= 1'b1;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
                txd     <= shift[0];
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && txb_valid) begin
            shift <= {1'b1, txb_data};
        end else if (busy && clk_cnt == bit_last) begin
            shift <= {1'b1, shift[8:1]};
        end
    end

endmodule

//--- frame_rx.sv
`timescale 1ns/1ps

module frame_rx import frame_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       rx_hold,
    input  logic       rx_clear,
    input  logic [7:0] rx_byte,
    input  logic       rx_byte_valid,
    output frame_u     frame,
    output logic [3:0] byte_count,
    output csum_t      body_sum
);

    localparam logic [3:0] cnt_full = 4'(frame_bytes);
    localparam logic [3:0] cnt_over = 4'(frame_bytes + 1);
    localparam logic [3:0] cnt_body = 4'(body_bytes);

    logic take;

    assign take = rx_byte_valid && !rx_hold;

    always_ff @(posedge clk) begin
        if (rst || rx_clear) begin
            byte_count <= '0;
            body_sum   <= '0;
        end else if (take) begin
            if (byte_count != cnt_over) byte_count <= byte_count + 1'b1; // long frames stick here
            if (byte_count < cnt_body) begin
                body_sum <= body_sum + {8'h00, rx_byte};
            end
        end
    end

    // bytes past the twelfth are counted but not stored
    always_ff @(posedge clk) begin
        if (take && byte_count < cnt_full) begin
            frame.b <= {frame.b[frame_bytes-2:0], rx_byte};
        end
    end

endmodule

//--- frame_tx.sv
`timescale 1ns/1ps

module frame_tx import frame_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       reply_load,
    input  body_t      tx_data,
    output logic       txb_valid,
    output logic [7:0] txb_data,
    input  logic       txb_ready,
    output logic       reply_done
);

    localparam int sw = 8 * frame_bytes;

    localparam logic [3:0] last_idx    = 4'(frame_bytes - 1);
    localparam logic [3:0] csum_hi_idx = 4'(body_bytes - 1);

    logic [sw-1:0] shreg;
    csum_t         sum;
    logic [3:0]    sent; // bytes already handed to the transmitter
    logic          xfer;

    assign xfer     = txb_valid && txb_ready;
    assign txb_data = shreg[sw-1 -: 8];

    always_ff @(posedge clk) begin
        if (rst) begin
            txb_valid  <= 1'b0;
            reply_done <= 1'b0;
            sent       <= '0;
        end else begin
            reply_done <= 1'b0;
            if (reply_load) begin
                txb_valid <= 1'b1;
                sent      <= '0;
            end else if (xfer) begin
                sent <= sent + 1'b1;
                if (sent == last_idx) begin
                    txb_valid  <= 1'b0;
                    reply_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reply_load) begin
            shreg <= {tx_data, 16'h0000};
            sum   <= {8'h00, tx_data[8*body_bytes-1 -: 8]};
        end else if (xfer) begin
            if (sent < csum_hi_idx) begin
                shreg <= {shreg[sw-9:0], 8'h00};
                sum   <= sum + {8'h00, shreg[sw-9 -: 8]}; // byte that moves to the top next
            end else if (sent == csum_hi_idx) begin
                shreg[sw-1 -: 8] <= sum[15:8];
            end else begin
                shreg[sw-1 -: 8] <= sum[7:0];
            end
        end
    end

endmodule

//--- frame_ctrl.sv
`timescale 1ns/1ps

module frame_ctrl import frame_pkg::*; #(
    parameter logic [31:0] msg_id = 32'h74697277
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       rx_eop,
    input  frame_u     frame,
    input  logic [3:0] byte_count,
    input  csum_t      body_sum,
    input  logic       reply_done,
    input  logic       tx_idle,
    output logic       rx_clear,
    output logic       rx_hold,
    output logic       reply_load,
    output logic       rx_valid,
    output body_t      rx_data,
    output logic       tx_busy
);

    localparam logic [1:0] st_recv  = 2'd0;
    localparam logic [1:0] st_reply = 2'd1;
    localparam logic [1:0] st_drain = 2'd2;

    logic [1:0] state;
    logic       accept;

    assign accept = rx_eop && state == st_recv
                    && byte_count == 4'(frame_bytes)
                    && frame.f.id == msg_id
                    && frame.f.csum == body_sum;

    // reception stays off for the whole reply
    assign rx_hold = state != st_recv;
    assign tx_busy = state != st_recv;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= st_recv;
            rx_clear   <= 1'b0;
            rx_valid   <= 1'b0;
            reply_load <= 1'b0;
        end else begin
            rx_clear   <= rx_eop; // every gap empties the buffer, good frame or not
            rx_valid   <= accept;
            reply_load <= accept;
            case (state)
                st_recv:  if (accept) state <= st_reply;
                st_reply: if (reply_done) state <= st_drain;
                default:  if (tx_idle) state <= st_recv; // last stop bit is out
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) rx_data <= {frame.f.id, frame.f.payload};
    end

endmodule

//--- uart_frame_link.sv
`timescale 1ns/1ps

module uart_frame_link import frame_pkg::*; #(
    parameter int          clk_freq = 1000000,
    parameter int          baud     = 125000,
    parameter logic [31:0] msg_id   = 32'h74697277
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  rx,
    output logic  tx,
    output body_t rx_data,
    output logic  rx_valid,
    input  body_t tx_data,
    output logic  tx_busy
);

    logic [7:0] rx_byte;
    logic       rx_byte_valid;
    logic       rx_eop;
    logic       rx_hold;
    logic       rx_clear;
    frame_u     frame;
    logic [3:0] byte_count;
    csum_t      body_sum;
    logic       reply_load;
    logic       reply_done;
    logic       txb_valid;
    logic [7:0] txb_data;
    logic       txb_ready;
    logic       tx_idle;

    frame_ctrl #(
        .msg_id (msg_id)
    ) i_frame_ctrl (
        .clk        (clk),
        .rst        (rst),
        .rx_eop     (rx_eop),
        .frame      (frame),
        .byte_count (byte_count),
        .body_sum   (body_sum),
        .reply_done (reply_done),
        .tx_idle    (tx_idle),
        .rx_clear   (rx_clear),
        .rx_hold    (rx_hold),
        .reply_load (reply_load),
        .rx_valid   (rx_valid),
        .rx_data    (rx_data),
        .tx_busy    (tx_busy)
    );

    uart_rx #(
        .clk_freq (clk_freq),
        .baud     (baud)
    ) i_uart_rx (
        .clk           (clk),
        .rst           (rst),
        .rxd           (rx),
        .rx_byte       (rx_byte),
        .rx_byte_valid (rx_byte_valid),
        .rx_eop        (rx_eop)
    );

    frame_rx i_frame_rx (
        .clk           (clk),
        .rst           (rst),
        .rx_hold       (rx_hold),
        .rx_clear      (rx_clear),
        .rx_byte       (rx_byte),
        .rx_byte_valid (rx_byte_valid),
        .frame         (frame),
        .byte_count    (byte_count),
        .body_sum      (body_sum)
    );

    frame_tx i_frame_tx (
        .clk        (clk),
        .rst        (rst),
        .reply_load (reply_load),
        .tx_data    (tx_data),
        .txb_valid  (txb_valid),
        .txb_data   (txb_data),
        .txb_ready  (txb_ready),
        .reply_done (reply_done)
    );

    uart_tx #(
        .clk_freq (clk_freq),
        .baud     (baud)
    ) i_uart_tx (
        .clk       (clk),
        .rst       (rst),
        .txb_valid (txb_valid),
        .txb_data  (txb_data),
        .txb_ready (txb_ready),
        .tx_idle   (tx_idle),
        .txd       (tx)
    );

endmodule

//--- tb_uart_frame_link.sv
`timescale 1ns/1ps

module tb_uart_frame_link import frame_pkg::*; ();

    localparam int          clk_freq  = 1000000;
    localparam int          baud      = 125000;
    localparam int          bit_clks  = clk_freq / baud;
    localparam logic [31:0] msg_id    = 32'h74697277;
    localparam int          n_rows    = 10;
    localparam int          sig_valid = 0;
    localparam int          sig_tx    = 1;
    localparam int          sig_busy  = 2;

    logic  clk;
    logic  rst;
    logic  rx;
    logic  tx;
    body_t rx_data;
    logic  rx_valid;
    body_t tx_data;
    logic  tx_busy;

    string       t_name   [n_rows];
    logic [31:0] t_id     [n_rows];
    logic [47:0] t_pay    [n_rows];
    logic        t_bad_cs [n_rows];
    int          t_count  [n_rows];
    logic        t_accept [n_rows];
    int          n_loaded;

    logic [7:0] fbytes [13];
    integer     seed;
    int         valid_pulses;
    int         tx_low_clks;
    int         busy_clks;
    int         reply_chars; // reply start bits seen so far in this row
    body_t      last_body; // last body the DUT should have accepted

    uart_frame_link #(
        .clk_freq (clk_freq),
        .baud     (baud),
        .msg_id   (msg_id)
    ) i_dut (
        .clk      (clk),
        .rst      (rst),
        .rx       (rx),
        .tx       (tx),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .tx_data  (tx_data),
        .tx_busy  (tx_busy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // counts valid pulses, clocks with the tx line low and clocks with busy high over the run
    always @(posedge clk) begin
        if (rx_valid === 1'b1) valid_pulses <= valid_pulses + 1;
        if (tx === 1'b0) tx_low_clks <= tx_low_clks + 1;
        if (tx_busy === 1'b1) busy_clks <= busy_clks + 1;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_body(input string name, input body_t exp, input body_t act);
        if (act !== exp) abort_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_csum(input string name, input csum_t exp, input csum_t act);
        if (act !== exp) abort_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) abort_run($sformatf("ERROR %s: expected %b, actual %b", name, exp, act));
    endtask

    function automatic logic watched(input int sel);
        case (sel)
            sig_valid: return rx_valid;
            sig_tx:    return tx;
            default:   return tx_busy;
        endcase
    endfunction

    task automatic wait_level(input int sel, input logic level, input int limit, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (watched(sel) !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (watched(sel) !== level) abort_run($sformatf("timed out waiting for %s", what));
    endtask

    task automatic add_row(input string name, input logic [31:0] id, input logic [47:0] pay,
                           input logic bad_cs, input int count, input logic accept);
        t_name[n_loaded]   = name;
        t_id[n_loaded]     = id;
        t_pay[n_loaded]    = pay;
        t_bad_cs[n_loaded] = bad_cs;
        t_count[n_loaded]  = count;
        t_accept[n_loaded] = accept;
        n_loaded++;
    endtask

    task automatic load_table();
        n_loaded = 0;
        add_row("good_first", msg_id, 48'h010203040506, 1'b0, 12, 1'b1);
        add_row("good_after_noise", msg_id, 48'hfedcba987654, 1'b0, 12, 1'b1);
        add_row("bad_id", 32'h74697278, 48'ha1a2a3a4a5a6, 1'b0, 12, 1'b0);
        add_row("bad_csum", msg_id, 48'h112233445566, 1'b1, 12, 1'b0);
        add_row("short_frame", msg_id, 48'h778899aabbcc, 1'b0, 11, 1'b0);
        add_row("long_frame", msg_id, 48'hddeeff001122, 1'b0, 13, 1'b0);
        add_row("good_all_ones", msg_id, 48'hffffffffffff, 1'b0, 12, 1'b1);
        for (int i = 0; i < 3; i++) begin
            add_row($sformatf("random_%0d", i), msg_id, {$random(seed), 16'($random(seed))},
                    1'b0, 12, 1'b1);
        end
    endtask

    task automatic build_frame(input int r);
        csum_t cs;
        body_t body;
        body = {t_id[r], t_pay[r]};
        cs   = '0;
        for (int i = 0; i < body_bytes; i++) begin
            fbytes[i] = body[8*body_bytes-1-8*i -: 8]; // msb first on the line
            cs        = cs + 16'(fbytes[i]);
        end
        if (t_bad_cs[r]) cs = cs ^ 16'h0001;
        fbytes[10] = cs[15:8];
        fbytes[11] = cs[7:0];
        fbytes[12] = 8'h5a; // extra byte of a long frame
    endtask

    task automatic drive_bit(input logic b);
        @(posedge clk);
        rx <= b;
        repeat (bit_clks - 1) @(posedge clk);
    endtask

    task automatic send_byte(input logic [7:0] d);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) drive_bit(d[i]);
        drive_bit(1'b1);
    endtask

    task automatic send_frame(input int r);
        for (int i = 0; i < t_count[r]; i++) send_byte(fbytes[i]);
        repeat (20) drive_bit(1'b1);
    endtask

    // samples each bit near its middle, starting from the falling edge of the start bit
    task automatic read_reply(input string name);
        logic [7:0] b [12];
        body_t      got_body;
        csum_t      exp_sum;
        for (int k = 0; k < frame_bytes; k++) begin
            wait_level(sig_tx, 1'b0, 4 * bit_clks, "a reply start bit");
            reply_chars++;
            repeat (bit_clks / 2 - 1) @(negedge clk);
            check_bit({name, " start bit"}, 1'b0, tx);
            check_bit({name, " busy during reply"}, 1'b1, tx_busy);
            for (int i = 0; i < 8; i++) begin
                repeat (bit_clks) @(negedge clk);
                b[k][i] = tx;
            end
            repeat (bit_clks) @(negedge clk);
            check_bit({name, " stop bit"}, 1'b1, tx);
        end
        exp_sum = '0;
        for (int k = 0; k < body_bytes; k++) begin
            got_body[8*body_bytes-1-8*k -: 8] = b[k];
            exp_sum = exp_sum + 16'(tx_data[8*body_bytes-1-8*k -: 8]);
        end
        check_body({name, " reply body"}, tx_data, got_body);
        check_csum({name, " reply checksum"}, exp_sum, {b[10], b[11]});
    endtask

    task automatic run_row(input int r);
        int pulses0;
        int low0;
        int busy0;
        build_frame(r);
        check_bit({t_name[r], " busy before frame"}, 1'b0, tx_busy);
        pulses0     = valid_pulses;
        low0        = tx_low_clks;
        busy0       = busy_clks;
        reply_chars = 0;
        @(posedge clk);
        tx_data <= {$random(seed), $random(seed), 16'($random(seed))};
        fork
            begin
                send_frame(r);
                // noise runs into the last reply byte, so the next frame follows it with no gap
                if (t_accept[r]) begin
                    wait_level(sig_busy, 1'b1, 4 * bit_clks, "the reply to start");
                    for (int i = 0; i < 2 * frame_bytes && reply_chars < frame_bytes; i++) begin
                        send_byte(8'($random(seed)));
                    end
                end
            end
            begin
                if (t_accept[r]) begin
                    wait_level(sig_valid, 1'b1, 200 * bit_clks, "rx_valid");
                    check_body({t_name[r], " rx_data"}, {t_id[r], t_pay[r]}, rx_data);
                    check_bit({t_name[r], " busy with valid"}, 1'b1, tx_busy);
                    read_reply(t_name[r]);
                    check_bit({t_name[r], " busy in last stop bit"}, 1'b1, tx_busy);
                    wait_level(sig_busy, 1'b0, 2 * bit_clks, "tx_busy to fall");
                    check_bit({t_name[r], " tx idle"}, 1'b1, tx);
                end
            end
        join
        @(negedge clk);
        check_bit({t_name[r], " valid pulse count"}, 1'b1,
                  (valid_pulses - pulses0) == (t_accept[r] ? 1 : 0));
        check_bit({t_name[r], " reply on tx"}, t_accept[r], tx_low_clks != low0);
        check_bit({t_name[r], " busy raised"}, t_accept[r], busy_clks != busy0);
        if (t_accept[r]) last_body = {t_id[r], t_pay[r]};
        check_body({t_name[r], " rx_data held"}, last_body, rx_data);
        check_bit({t_name[r], " busy after frame"}, 1'b0, tx_busy);
    endtask

    initial begin
        seed         = 32'h8aa1;
        rst          = 1'b1;
        rx           = 1'b1;
        tx_data      = '0;
        valid_pulses = 0;
        tx_low_clks  = 0;
        busy_clks    = 0;
        reply_chars  = 0;
        last_body    = '0;
        load_table();
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        repeat (2 * bit_clks) @(negedge clk);
        for (int r = 0; r < n_rows; r++) run_row(r);
        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- uart_frame_link.f
frame_pkg.sv
uart_rx.sv
uart_tx.sv
frame_rx.sv
frame_tx.sv
frame_ctrl.sv
uart_frame_link.sv
tb_uart_frame_link.sv

//--- Bender.yml
package:
  name: uart_frame_link

sources:
  - frame_pkg.sv
  - uart_rx.sv
  - uart_tx.sv
  - frame_rx.sv
  - frame_tx.sv
  - frame_ctrl.sv
  - uart_frame_link.sv
  - target: test
    files:
      - tb_uart_frame_link.sv
